// File: include/ps_config.svh
`ifndef PS_CONFIG_SVH
`define PS_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// widths and counts
//////////////////////////////////////////////////////////////////////

`define PS_GPIO_W  24
`define PS_IRQ_W   8
// osc0, osc1, la
`define PS_STREAMS 3
`define PS_CNT_W   32
// interrupt status: external lines then one frame-done bit per stream
`define PS_STAT_W  (`PS_IRQ_W + `PS_STREAMS)

// reads back as ascii "PSYS"
`define PS_ID 32'h5053_5953

//////////////////////////////////////////////////////////////////////
// register map, byte offsets
//////////////////////////////////////////////////////////////////////

`define PS_REG_ID         8'h00
`define PS_REG_GPIO_OUT   8'h04
`define PS_REG_GPIO_DIR   8'h08
`define PS_REG_GPIO_IN    8'h0C
`define PS_REG_IRQ_STAT   8'h10
`define PS_REG_IRQ_MASK   8'h14
`define PS_REG_STR_EN     8'h18
// per stream block: bytes +0, frames +4, last word +8
`define PS_REG_STR_BASE   8'h20
`define PS_REG_STR_STRIDE 8'h10

`endif

// File: src/ps_pkg.sv
`default_nettype none

`include "ps_config.svh"

package ps_pkg;

  //////////////////////////////////////////////////////////////////////
  // stream word
  //////////////////////////////////////////////////////////////////////

  // same 16 bits seen two ways
  // osc view: two 8-bit samples, [0] in the low byte
  // la view: one 16-bit logic analyzer sample
  typedef union packed {
    logic [1:0][7:0] osc;
    logic [15:0]     la;
  } stream_word_u;

  //////////////////////////////////////////////////////////////////////
  // interrupts and stream select
  //////////////////////////////////////////////////////////////////////

  // external interrupt lines, one bit per source
  typedef logic [`PS_IRQ_W-1:0] irq_t;

  // 0 osc0, 1 osc1, 2 la
  typedef logic [1:0] stream_idx_t;

endpackage

`default_nettype wire

// File: src/stream_sink.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps_config.svh"

module stream_sink
  import ps_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  // stream enable, straight from the register
  input  logic                 enable,
  input  stream_word_u         tdata,
  input  logic [1:0]           tkeep,
  input  logic                 tlast,
  input  logic                 tvalid,
  output logic                 tready,
  output logic [`PS_CNT_W-1:0] byte_cnt,
  output logic [`PS_CNT_W-1:0] frame_cnt,
  output stream_word_u         last_word,
  output logic                 frame_done
);

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  logic       beat;
  // bytes carried by this beat, 0..2
  logic [1:0] keep_n;

  // disabled sink holds the producer off
  assign tready = enable;
  assign beat   = tvalid & tready;

  // popcount of the two keep bits
  assign keep_n = {1'b0, tkeep[0]} + {1'b0, tkeep[1]};

  // one cycle per accepted tlast
  // status latch in irq_ctrl picks it up on the same edge as frame_cnt
  assign frame_done = beat & tlast;

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  // both counters wrap silently
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_cnt <= '0;
    end else if (beat) begin
      byte_cnt <= byte_cnt + {{(`PS_CNT_W-2){1'b0}}, keep_n};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_cnt <= '0;
    end else if (frame_done) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // last accepted word
  //////////////////////////////////////////////////////////////////////

  // stored whole, keep only affects the byte count
  // bus side decides osc or la view
  always_ff @(posedge clk) begin
    if (beat) begin
      last_word <= tdata;
    end
  end

endmodule

`default_nettype wire

// File: src/gpio_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps_config.svh"

module gpio_ctrl (
  input  logic                  clk,
  input  logic                  arst_n,
  // write strobes from the bus decode
  input  logic                  out_we,
  input  logic                  dir_we,
  input  logic [`PS_GPIO_W-1:0] wdata,
  // pad side
  input  logic [`PS_GPIO_W-1:0] gpio_i,
  output logic [`PS_GPIO_W-1:0] gpio_o,
  output logic [`PS_GPIO_W-1:0] gpio_t,
  // register side, read back by the bus
  output logic [`PS_GPIO_W-1:0] gpio_out_q,
  output logic [`PS_GPIO_W-1:0] gpio_dir_q,
  output logic [`PS_GPIO_W-1:0] gpio_in_sync
);

  //////////////////////////////////////////////////////////////////////
  // output and direction registers
  //////////////////////////////////////////////////////////////////////

  // dir bit set means pin driven
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
    end else begin
      if (out_we) begin
        gpio_out_q <= wdata;
      end
      if (dir_we) begin
        gpio_dir_q <= wdata;
      end
    end
  end

  // tristate enable is active high, so all pins float after reset
  assign gpio_o = gpio_out_q;
  assign gpio_t = ~gpio_dir_q;

  //////////////////////////////////////////////////////////////////////
  // input synchronizer
  //////////////////////////////////////////////////////////////////////

  logic [`PS_GPIO_W-1:0] gpio_meta;

  // two flops, pins are asynchronous to clk
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_meta    <= '0;
      gpio_in_sync <= '0;
    end else begin
      gpio_meta    <= gpio_i;
      gpio_in_sync <= gpio_meta;
    end
  end

endmodule

`default_nettype wire

// File: src/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps_config.svh"

module irq_ctrl
  import ps_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  // asynchronous external sources
  input  irq_t                   irq_in,
  // one pulse per stream, already in the clk domain
  input  logic [`PS_STREAMS-1:0] frame_done,
  input  logic                   stat_clr_we,
  input  logic                   mask_we,
  input  logic [`PS_STAT_W-1:0]  wdata,
  output logic [`PS_STAT_W-1:0]  irq_stat,
  output logic [`PS_STAT_W-1:0]  irq_mask,
  output logic                   irq
);

  //////////////////////////////////////////////////////////////////////
  // external line sync and edge detect
  //////////////////////////////////////////////////////////////////////

  irq_t irq_meta;
  irq_t irq_sync;
  // previous synced value, for the rising edge
  irq_t irq_prev;
  irq_t irq_rise;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irq_meta <= '0;
      irq_sync <= '0;
      irq_prev <= '0;
    end else begin
      irq_meta <= irq_in;
      irq_sync <= irq_meta;
      irq_prev <= irq_sync;
    end
  end

  assign irq_rise = irq_sync & ~irq_prev;

  //////////////////////////////////////////////////////////////////////
  // status, mask, combined output
  //////////////////////////////////////////////////////////////////////

  logic [`PS_STAT_W-1:0] events;
  logic [`PS_STAT_W-1:0] clr;

  // stream bits sit above the external lines
  assign events = {frame_done, irq_rise};
  assign clr    = stat_clr_we ? wdata : '0;

  // a new event wins over a clear of the same bit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irq_stat <= '0;
      irq_mask <= '0;
    end else begin
      irq_stat <= (irq_stat & ~clr) | events;
      if (mask_we) begin
        irq_mask <= wdata;
      end
    end
  end

  assign irq = |(irq_stat & irq_mask);

endmodule

`default_nettype wire

// File: src/ps_system.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps_config.svh"

module ps_system
  import ps_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  // APB slave, no wait states
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  // oscilloscope channel 0
  input  stream_word_u          osc0_tdata,
  input  logic [1:0]            osc0_tkeep,
  input  logic                  osc0_tlast,
  input  logic                  osc0_tvalid,
  output logic                  osc0_tready,
  // oscilloscope channel 1
  input  stream_word_u          osc1_tdata,
  input  logic [1:0]            osc1_tkeep,
  input  logic                  osc1_tlast,
  input  logic                  osc1_tvalid,
  output logic                  osc1_tready,
  // logic analyzer
  input  stream_word_u          la_tdata,
  input  logic [1:0]            la_tkeep,
  input  logic                  la_tlast,
  input  logic                  la_tvalid,
  output logic                  la_tready,
  // interrupts
  input  irq_t                  irq_in,
  output logic                  irq,
  // GPIO pads
  input  logic [`PS_GPIO_W-1:0] gpio_i,
  output logic [`PS_GPIO_W-1:0] gpio_o,
  output logic [`PS_GPIO_W-1:0] gpio_t
);

  // offsets inside one stream block
  localparam logic [7:0] STR_BYTES  = 8'h00;
  localparam logic [7:0] STR_FRAMES = 8'h04;
  localparam logic [7:0] STR_LAST   = 8'h08;

  //////////////////////////////////////////////////////////////////////
  // stream sinks
  //////////////////////////////////////////////////////////////////////

  logic [`PS_STREAMS-1:0] str_en;
  logic [`PS_STREAMS-1:0] frame_done;

  // per stream views, index follows stream_idx_t
  stream_word_u         s_tdata   [`PS_STREAMS];
  logic [1:0]           s_tkeep   [`PS_STREAMS];
  logic                 s_tlast   [`PS_STREAMS];
  logic                 s_tvalid  [`PS_STREAMS];
  logic                 s_tready  [`PS_STREAMS];
  logic [`PS_CNT_W-1:0] byte_cnt  [`PS_STREAMS];
  logic [`PS_CNT_W-1:0] frame_cnt [`PS_STREAMS];
  stream_word_u         last_word [`PS_STREAMS];

  assign s_tdata[0]  = osc0_tdata;
  assign s_tkeep[0]  = osc0_tkeep;
  assign s_tlast[0]  = osc0_tlast;
  assign s_tvalid[0] = osc0_tvalid;
  assign osc0_tready = s_tready[0];

  assign s_tdata[1]  = osc1_tdata;
  assign s_tkeep[1]  = osc1_tkeep;
  assign s_tlast[1]  = osc1_tlast;
  assign s_tvalid[1] = osc1_tvalid;
  assign osc1_tready = s_tready[1];

  assign s_tdata[2]  = la_tdata;
  assign s_tkeep[2]  = la_tkeep;
  assign s_tlast[2]  = la_tlast;
  assign s_tvalid[2] = la_tvalid;
  assign la_tready   = s_tready[2];

  for (genvar i = 0; i < `PS_STREAMS; i++) begin : g_sink
    stream_sink sink_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (str_en[i]),
      .tdata      (s_tdata[i]),
      .tkeep      (s_tkeep[i]),
      .tlast      (s_tlast[i]),
      .tvalid     (s_tvalid[i]),
      .tready     (s_tready[i]),
      .byte_cnt   (byte_cnt[i]),
      .frame_cnt  (frame_cnt[i]),
      .last_word  (last_word[i]),
      .frame_done (frame_done[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  logic        apb_acc;
  logic        reg_hit;
  logic        reg_ro;
  logic        wr_ok;
  logic [31:0] rdata;
  // stream block decode
  logic [7:0]  str_off;
  logic [7:0]  str_slot;
  logic [7:0]  str_sub;
  logic        str_hit;
  stream_idx_t str_idx;

  assign apb_acc = psel & penable;

  assign str_off  = paddr - `PS_REG_STR_BASE;
  assign str_slot = str_off / `PS_REG_STR_STRIDE;
  assign str_sub  = str_off % `PS_REG_STR_STRIDE;
  assign str_hit  = (paddr >= `PS_REG_STR_BASE) && (str_slot < 8'(`PS_STREAMS));
  assign str_idx  = str_slot[1:0];

  logic [`PS_GPIO_W-1:0] gpio_out_q;
  logic [`PS_GPIO_W-1:0] gpio_dir_q;
  logic [`PS_GPIO_W-1:0] gpio_in_sync;
  logic [`PS_STAT_W-1:0] irq_stat;
  logic [`PS_STAT_W-1:0] irq_mask;

  // hit, read-only flag and read data in one pass
  always_comb begin
    reg_hit = 1'b1;
    reg_ro  = 1'b0;
    rdata   = '0;
    case (paddr)
      `PS_REG_ID: begin
        reg_ro = 1'b1;
        rdata  = `PS_ID;
      end
      `PS_REG_GPIO_OUT: rdata[`PS_GPIO_W-1:0] = gpio_out_q;
      `PS_REG_GPIO_DIR: rdata[`PS_GPIO_W-1:0] = gpio_dir_q;
      `PS_REG_GPIO_IN: begin
        reg_ro = 1'b1;
        rdata[`PS_GPIO_W-1:0] = gpio_in_sync;
      end
      `PS_REG_IRQ_STAT: rdata[`PS_STAT_W-1:0] = irq_stat;
      `PS_REG_IRQ_MASK: rdata[`PS_STAT_W-1:0] = irq_mask;
      `PS_REG_STR_EN:   rdata[`PS_STREAMS-1:0] = str_en;
      default: begin
        // stream blocks are all read-only
        reg_ro = 1'b1;
        if (str_hit) begin
          case (str_sub)
            STR_BYTES:  rdata = byte_cnt[str_idx];
            STR_FRAMES: rdata = frame_cnt[str_idx];
            // raw word, the reader picks osc or la view
            STR_LAST:   rdata[15:0] = last_word[str_idx];
            default:    reg_hit = 1'b0;
          endcase
        end else begin
          reg_hit = 1'b0;
        end
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // bus response
  //////////////////////////////////////////////////////////////////////

  assign pready  = 1'b1;
  assign prdata  = rdata;
  // unmapped or write to a read-only register
  assign pslverr = apb_acc & (~reg_hit | (pwrite & reg_ro));
  // erroring writes are dropped
  assign wr_ok   = apb_acc & pwrite & reg_hit & ~reg_ro;

  //////////////////////////////////////////////////////////////////////
  // stream enable register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      str_en <= '0;
    end else if (wr_ok && paddr == `PS_REG_STR_EN) begin
      str_en <= pwdata[`PS_STREAMS-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // GPIO and interrupt blocks
  //////////////////////////////////////////////////////////////////////

  gpio_ctrl gpio_i_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .out_we       (wr_ok && paddr == `PS_REG_GPIO_OUT),
    .dir_we       (wr_ok && paddr == `PS_REG_GPIO_DIR),
    .wdata        (pwdata[`PS_GPIO_W-1:0]),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_t       (gpio_t),
    .gpio_out_q   (gpio_out_q),
    .gpio_dir_q   (gpio_dir_q),
    .gpio_in_sync (gpio_in_sync)
  );

  // status write is write-one-to-clear
  irq_ctrl irq_i_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .irq_in      (irq_in),
    .frame_done  (frame_done),
    .stat_clr_we (wr_ok && paddr == `PS_REG_IRQ_STAT),
    .mask_we     (wr_ok && paddr == `PS_REG_IRQ_MASK),
    .wdata       (pwdata[`PS_STAT_W-1:0]),
    .irq_stat    (irq_stat),
    .irq_mask    (irq_mask),
    .irq         (irq)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // release just after an edge, like every other input
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/ps_system_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps_config.svh"

module ps_system_props (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   psel,
  input logic                   penable,
  input logic                   pready,
  input logic                   pslverr,
  input logic [`PS_STREAMS-1:0] str_en,
  input logic                   osc0_tready,
  input logic                   osc1_tready,
  input logic                   la_tready,
  input logic                   irq,
  input logic [`PS_STAT_W-1:0]  irq_stat,
  input logic [`PS_STAT_W-1:0]  irq_mask,
  input logic [`PS_GPIO_W-1:0]  gpio_t,
  input logic [`PS_GPIO_W-1:0]  gpio_dir_q
);

  //////////////////////////////////////////////////////////////////////
  // bus
  //////////////////////////////////////////////////////////////////////

  // no wait states ever
  pready_high: assert property (@(posedge clk) pready)
    else $error("pready went low");

  // error only in the access phase
  slverr_in_access: assert property (
    @(posedge clk) disable iff (!arst_n) pslverr |-> (psel && penable))
    else $error("pslverr outside an access cycle");

  //////////////////////////////////////////////////////////////////////
  // streams, interrupts, gpio
  //////////////////////////////////////////////////////////////////////

  // disabled stream never accepts
  tready_gated: assert property (
    @(posedge clk) disable iff (!arst_n)
    (({la_tready, osc1_tready, osc0_tready} & ~str_en) == '0))
    else $error("tready high on a disabled stream");

  irq_combined: assert property (
    @(posedge clk) disable iff (!arst_n) irq == |(irq_stat & irq_mask))
    else $error("irq differs from masked status");

  gpio_t_inverse: assert property (
    @(posedge clk) disable iff (!arst_n) gpio_t == ~gpio_dir_q)
    else $error("gpio_t is not the inverse of direction");

endmodule

`default_nettype wire

// File: tb/ps_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps_config.svh"

module ps_system_tb
  import ps_pkg::*;
();

  localparam int STREAM_CYCLES = 400;
  localparam int BP_CYCLES     = 250;
  // remaining tests and register reads stay under 350 cycles
  localparam int MAX_CYCLES    = 4 * (STREAM_CYCLES + BP_CYCLES + 350);

  logic                  clk;
  logic                  arst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [7:0]            paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  // stream inputs, index 0 osc0, 1 osc1, 2 la
  stream_word_u          s_data  [`PS_STREAMS];
  logic [1:0]            s_keep  [`PS_STREAMS];
  logic                  s_last  [`PS_STREAMS];
  logic                  s_valid [`PS_STREAMS];
  logic                  s_ready [`PS_STREAMS];
  irq_t                  irq_in;
  logic                  irq;
  logic [`PS_GPIO_W-1:0] gpio_in;
  logic [`PS_GPIO_W-1:0] gpio_o;
  logic [`PS_GPIO_W-1:0] gpio_t;

  //////////////////////////////////////////////////////////////////////
  // clock, DUT, properties
  //////////////////////////////////////////////////////////////////////

  tb_clk_gen #(.RESET_CYCLES(8)) clk_gen_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  ps_system dut_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .osc0_tdata  (s_data[0]),
    .osc0_tkeep  (s_keep[0]),
    .osc0_tlast  (s_last[0]),
    .osc0_tvalid (s_valid[0]),
    .osc0_tready (s_ready[0]),
    .osc1_tdata  (s_data[1]),
    .osc1_tkeep  (s_keep[1]),
    .osc1_tlast  (s_last[1]),
    .osc1_tvalid (s_valid[1]),
    .osc1_tready (s_ready[1]),
    .la_tdata    (s_data[2]),
    .la_tkeep    (s_keep[2]),
    .la_tlast    (s_last[2]),
    .la_tvalid   (s_valid[2]),
    .la_tready   (s_ready[2]),
    .irq_in      (irq_in),
    .irq         (irq),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_o),
    .gpio_t      (gpio_t)
  );

  bind ps_system ps_system_props props_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .pslverr     (pslverr),
    .str_en      (str_en),
    .osc0_tready (osc0_tready),
    .osc1_tready (osc1_tready),
    .la_tready   (la_tready),
    .irq         (irq),
    .irq_stat    (irq_stat),
    .irq_mask    (irq_mask),
    .gpio_t      (gpio_t),
    .gpio_dir_q  (gpio_dir_q)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model and bookkeeping
  //////////////////////////////////////////////////////////////////////

  logic [31:0]            exp_bytes  [`PS_STREAMS];
  logic [31:0]            exp_frames [`PS_STREAMS];
  stream_word_u           exp_last   [`PS_STREAMS];
  logic [`PS_STREAMS-1:0] en_model;
  logic [`PS_GPIO_W-1:0]  exp_out;
  logic [`PS_GPIO_W-1:0]  exp_dir;
  logic [`PS_STAT_W-1:0]  exp_stat;
  logic [`PS_STAT_W-1:0]  exp_mask;
  logic [31:0]            rng_state;
  string                  cur_test;
  int                     check_cnt;
  int                     fail_cnt;
  int                     test_fail;
  int                     cycle_cnt;

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    check_cnt++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
      fail_cnt++;
      test_fail++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_fail = 0;
  endtask

  task automatic end_test();
    if (test_fail == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d checks failed", cur_test, test_fail);
    end
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////////////////////////

  // entered 1 ns after an edge, returns 1 ns after the access edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // mid access cycle
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_value($sformatf("write %h pslverr", addr), 32'd0, 32'(err));
  endtask

  task automatic read_check(input logic [7:0] addr, input string what,
                            input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rd, err);
    check_value({what, " pslverr"}, 32'd0, 32'(err));
    check_value(what, exp, rd);
  endtask

  task automatic check_irq();
    check_value("irq pin", 32'(|(exp_stat & exp_mask)), 32'(irq));
  endtask

  //////////////////////////////////////////////////////////////////////
  // streams
  //////////////////////////////////////////////////////////////////////

  task automatic account_beat(input int s);
    exp_bytes[s] = exp_bytes[s] + 32'($countones(s_keep[s]));
    exp_last[s]  = s_data[s];
    if (s_last[s]) begin
      exp_frames[s]               = exp_frames[s] + 32'd1;
      exp_stat[`PS_IRQ_W + s]     = 1'b1;
    end
  endtask

  // hold forces tvalid high on those streams
  task automatic run_streams(input int n, input logic [2:0] active, input logic [2:0] hold);
    logic [31:0] r;
    for (int c = 0; c < n; c++) begin
      for (int s = 0; s < `PS_STREAMS; s++) begin
        r          = next_random();
        s_valid[s] = active[s] & (hold[s] | r[0] | r[1]);
        s_keep[s]  = r[3:2];
        // frames average eight beats
        s_last[s]  = (r[6:4] == 3'd0);
        s_data[s]  = r[31:16];
      end
      @(negedge clk);
      for (int s = 0; s < `PS_STREAMS; s++) begin
        check_value($sformatf("s%0d tready", s), 32'(en_model[s]), 32'(s_ready[s]));
        if (s_valid[s] && en_model[s]) begin
          account_beat(s);
        end
      end
      @(posedge clk);
      #1;
    end
    for (int s = 0; s < `PS_STREAMS; s++) begin
      s_valid[s] = 1'b0;
      s_last[s]  = 1'b0;
    end
  endtask

  task automatic check_stream(input int s);
    logic [7:0]   base;
    logic [31:0]  rd;
    logic         err;
    stream_word_u got;
    base = 8'(`PS_REG_STR_BASE + `PS_REG_STR_STRIDE * s);
    read_check(base, $sformatf("s%0d bytes", s), exp_bytes[s]);
    read_check(base + 8'h04, $sformatf("s%0d frames", s), exp_frames[s]);
    apb_xfer(1'b0, base + 8'h08, 32'd0, rd, err);
    check_value($sformatf("s%0d last pslverr", s), 32'd0, 32'(err));
    got = rd[15:0];
    // both views of the same word
    check_value($sformatf("s%0d osc[0]", s), 32'(exp_last[s].osc[0]), 32'(got.osc[0]));
    check_value($sformatf("s%0d osc[1]", s), 32'(exp_last[s].osc[1]), 32'(got.osc[1]));
    check_value($sformatf("s%0d la", s), 32'(exp_last[s].la), 32'(got.la));
    check_value($sformatf("s%0d last upper", s), 32'd0, 32'(rd[31:16]));
  endtask

  task automatic check_regs();
    read_check(`PS_REG_GPIO_OUT, "gpio out", 32'(exp_out));
    read_check(`PS_REG_GPIO_DIR, "gpio dir", 32'(exp_dir));
    read_check(`PS_REG_IRQ_MASK, "irq mask", 32'(exp_mask));
    read_check(`PS_REG_IRQ_STAT, "irq status", 32'(exp_stat));
    read_check(`PS_REG_STR_EN, "stream enable", 32'(en_model));
    for (int s = 0; s < `PS_STREAMS; s++) begin
      check_stream(s);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_test();
    begin_test("reset");
    check_value("gpio_t", 32'({`PS_GPIO_W{1'b1}}), 32'(gpio_t));
    check_value("gpio_o", 32'd0, 32'(gpio_o));
    check_value("treadys", 32'd0, 32'({s_ready[2], s_ready[1], s_ready[0]}));
    check_value("irq", 32'd0, 32'(irq));
    read_check(`PS_REG_ID, "id", `PS_ID);
    end_test();
  endtask

  task automatic gpio_test();
    logic [31:0] r;
    begin_test("gpio");
    for (int i = 0; i < 4; i++) begin
      r       = next_random();
      exp_out = r[`PS_GPIO_W-1:0];
      write_reg(`PS_REG_GPIO_OUT, 32'(exp_out));
      r       = next_random();
      exp_dir = r[`PS_GPIO_W-1:0];
      write_reg(`PS_REG_GPIO_DIR, 32'(exp_dir));
      read_check(`PS_REG_GPIO_OUT, "gpio out", 32'(exp_out));
      read_check(`PS_REG_GPIO_DIR, "gpio dir", 32'(exp_dir));
      check_value("gpio_o pins", 32'(exp_out), 32'(gpio_o));
      check_value("gpio_t pins", {8'd0, ~exp_dir}, 32'(gpio_t));
      r       = next_random();
      gpio_in = r[`PS_GPIO_W-1:0];
      // more than the two synchronizer stages
      settle(3);
      read_check(`PS_REG_GPIO_IN, "gpio in", 32'(gpio_in));
    end
    end_test();
  endtask

  task automatic stream_test();
    begin_test("streams");
    write_reg(`PS_REG_STR_EN, 32'h7);
    en_model = 3'b111;
    run_streams(STREAM_CYCLES, 3'b111, 3'b000);
    for (int s = 0; s < `PS_STREAMS; s++) begin
      check_stream(s);
    end
    read_check(`PS_REG_IRQ_STAT, "frame status", 32'(exp_stat));
    end_test();
  endtask

  // osc1 disabled with its producer stuck valid
  task automatic backpressure_test();
    begin_test("backpressure");
    write_reg(`PS_REG_STR_EN, 32'h5);
    en_model = 3'b101;
    run_streams(BP_CYCLES, 3'b111, 3'b010);
    for (int s = 0; s < `PS_STREAMS; s++) begin
      check_stream(s);
    end
    end_test();
  endtask

  task automatic irq_test();
    logic [31:0] r;
    int          k;
    begin_test("interrupts");
    r = next_random();
    k = int'(r[2:0]);
    write_reg(`PS_REG_IRQ_STAT, 32'h7FF);
    exp_stat = '0;
    write_reg(`PS_REG_IRQ_MASK, 32'd0);
    exp_mask = '0;
    read_check(`PS_REG_IRQ_STAT, "status cleared", 32'd0);
    // external pulse, two cycles wide
    irq_in[k] = 1'b1;
    settle(2);
    irq_in = '0;
    settle(2);
    exp_stat[k] = 1'b1;
    read_check(`PS_REG_IRQ_STAT, "status after irq_in", 32'(exp_stat));
    check_irq();
    write_reg(`PS_REG_IRQ_MASK, 32'(1 << k));
    exp_mask[k] = 1'b1;
    check_irq();
    // one-beat frame on osc0
    s_valid[0] = 1'b1;
    s_last[0]  = 1'b1;
    s_keep[0]  = 2'b11;
    s_data[0]  = r[31:16];
    @(negedge clk);
    account_beat(0);
    @(posedge clk);
    #1;
    s_valid[0] = 1'b0;
    s_last[0]  = 1'b0;
    read_check(`PS_REG_IRQ_STAT, "status after frame", 32'(exp_stat));
    check_irq();
    write_reg(`PS_REG_IRQ_STAT, 32'(1 << k));
    exp_stat[k] = 1'b0;
    read_check(`PS_REG_IRQ_STAT, "status after clear", 32'(exp_stat));
    check_irq();
    write_reg(`PS_REG_IRQ_MASK, 32'(1 << `PS_IRQ_W));
    exp_mask = '0;
    exp_mask[`PS_IRQ_W] = 1'b1;
    check_irq();
    write_reg(`PS_REG_IRQ_STAT, 32'(1 << `PS_IRQ_W));
    exp_stat[`PS_IRQ_W] = 1'b0;
    check_irq();
    read_check(`PS_REG_IRQ_STAT, "status empty", 32'(exp_stat));
    end_test();
  endtask

  task automatic bus_error_test();
    logic [7:0]  bad_addr [5];
    logic [7:0]  ro_addr  [5];
    logic [31:0] rd;
    logic        err;
    bad_addr = '{8'h1C, 8'h2C, 8'h50, 8'h80, 8'hFF};
    ro_addr  = '{`PS_REG_ID, `PS_REG_GPIO_IN, 8'h20, 8'h34, 8'h48};
    begin_test("bus errors");
    foreach (bad_addr[i]) begin
      apb_xfer(1'b0, bad_addr[i], 32'd0, rd, err);
      check_value($sformatf("read %h pslverr", bad_addr[i]), 32'd1, 32'(err));
      apb_xfer(1'b1, bad_addr[i], next_random(), rd, err);
      check_value($sformatf("write %h pslverr", bad_addr[i]), 32'd1, 32'(err));
    end
    // read-only targets
    foreach (ro_addr[i]) begin
      apb_xfer(1'b1, ro_addr[i], next_random(), rd, err);
      check_value($sformatf("write %h pslverr", ro_addr[i]), 32'd1, 32'(err));
    end
    check_regs();
    read_check(`PS_REG_ID, "id after write", `PS_ID);
    end_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    irq_in    = '0;
    gpio_in   = '0;
    rng_state = 32'd63418;
    check_cnt = 0;
    fail_cnt  = 0;
    en_model  = '0;
    exp_out   = '0;
    exp_dir   = '0;
    exp_stat  = '0;
    exp_mask  = '0;
    for (int s = 0; s < `PS_STREAMS; s++) begin
      s_data[s]     = '0;
      s_keep[s]     = '0;
      s_last[s]     = 1'b0;
      s_valid[s]    = 1'b0;
      exp_bytes[s]  = '0;
      exp_frames[s] = '0;
      exp_last[s]   = '0;
    end
    @(posedge arst_n);
    settle(1);
    reset_test();
    gpio_test();
    stream_test();
    backpressure_test();
    irq_test();
    bus_error_test();
    $display("summary: %0d checks passed, %0d failed", check_cnt - fail_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
src/ps_pkg.sv
src/stream_sink.sv
src/gpio_ctrl.sv
src/irq_ctrl.sv
src/ps_system.sv
tb/tb_clk_gen.sv
tb/ps_system_props.sv
tb/ps_system_tb.sv

// File: Makefile
TOP := ps_system_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# a run that stops early prints neither message and counts as failed
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
